//--- hdl/modarith_pkg.sv
// Shared types for the modular arithmetic unit
// Data width is fixed here since packed structs carry it across ports
// All values are unsigned, no signed operands supported

package modarith_pkg;

  ////////////////////////////////////////
  // Widths and data types
  ////////////////////////////////////////

  // Operand, modulus and result width
  localparam int DATA_SIZE = 32;

  // Unsigned operand, modulus or result
  typedef logic [DATA_SIZE-1:0] data_t;

  // One reduction request, value mod modulo
  typedef struct packed {
    data_t value;
    data_t modulo;
  } reduce_cmd_t;

  ////////////////////////////////////////
  // State machine encodings
  ////////////////////////////////////////

  // Remainder engine
  typedef enum logic {
    red_idle,
    red_subtract
  } reducer_state_t;

  // Reducer arbiter, release spends one cycle after done
  typedef enum logic [1:0] {
    arb_idle,
    arb_busy,
    arb_release
  } arbiter_state_t;

  // Add and multiply engines
  typedef enum logic [2:0] {
    eng_idle,
    eng_reduce_a,
    eng_reduce_b,
    eng_compute,
    eng_finish
  } engine_state_t;

  // Which engine holds the reducer
  typedef enum logic {
    own_adder,
    own_multiplier
  } owner_t;

endpackage

//--- hdl/mod_reducer.sv
// Remainder by repeated subtraction, one subtraction per cycle
// Ready comes q + 2 edges after start is raised, q = value / modulo
// Zero modulus returns the value unchanged
// Start is only sampled while idle

`timescale 1ns/1ns

module mod_reducer (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  modarith_pkg::reduce_cmd_t cmd,
  output logic                      ready,
  output modarith_pkg::data_t       result
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  modarith_pkg::reducer_state_t state;

  // Working remainder and latched divisor
  modarith_pkg::data_t rem;
  modarith_pkg::data_t modulo_r;

  // Another subtraction still needed
  logic sub_en;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Equal case goes through one more subtraction and lands on zero
  assign sub_en = (modulo_r != '0) && (rem >= modulo_r);

  always_ff @(posedge CLK) begin
    if (state == modarith_pkg::red_idle) begin
      if (start) begin
        rem      <= cmd.value;
        modulo_r <= cmd.modulo;
      end
    end else if (sub_en) begin
      rem <= rem - modulo_r;
    end
  end

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= modarith_pkg::red_idle;
      ready  <= 1'b0;
      result <= '0;
    end else begin
      // Ready is a single cycle pulse
      ready <= 1'b0;
      case (state)
        modarith_pkg::red_idle: begin
          if (start) begin
            state <= modarith_pkg::red_subtract;
          end
        end
        modarith_pkg::red_subtract: begin
          // Done once remainder is below modulus, or modulus is zero
          if (!sub_en) begin
            result <= rem;
            ready  <= 1'b1;
            state  <= modarith_pkg::red_idle;
          end
        end
        default: begin
          state <= modarith_pkg::red_idle;
        end
      endcase
    end
  end

endmodule

//--- hdl/reducer_arbiter.sv
// Round-robin sharing of one reducer between the add and multiply engines
// Requests are levels held until done, done is a one-cycle pulse
// One release cycle follows each done before the next grant

`timescale 1ns/1ns

module reducer_arbiter (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      add_req,
  input  modarith_pkg::reduce_cmd_t add_cmd,
  input  logic                      mul_req,
  input  modarith_pkg::reduce_cmd_t mul_cmd,
  output logic                      add_done,
  output logic                      mul_done,
  output modarith_pkg::data_t       red_result,
  output logic                      red_start,
  output modarith_pkg::reduce_cmd_t red_cmd,
  input  logic                      red_ready,
  input  modarith_pkg::data_t       red_value
);

  modarith_pkg::arbiter_state_t state;

  // Current owner, also the last one served
  modarith_pkg::owner_t owner;

  // Multiplier wins this pick
  logic grant_mul;

  ////////////////////////////////////////
  // Grant selection
  ////////////////////////////////////////

  // On a tie the engine not served last goes first
  always_comb begin
    if (add_req && mul_req) begin
      grant_mul = (owner == modarith_pkg::own_adder);
    end else begin
      grant_mul = mul_req;
    end
  end

  // Command held for the reducer
  always_ff @(posedge CLK) begin
    if (state == modarith_pkg::arb_idle && (add_req || mul_req)) begin
      red_cmd <= grant_mul ? mul_cmd : add_cmd;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= modarith_pkg::arb_idle;
      owner     <= modarith_pkg::own_multiplier;
      red_start <= 1'b0;
    end else begin
      red_start <= 1'b0;
      case (state)
        modarith_pkg::arb_idle: begin
          if (add_req || mul_req) begin
            red_start <= 1'b1;
            owner     <= grant_mul ? modarith_pkg::own_multiplier
                                   : modarith_pkg::own_adder;
            state     <= modarith_pkg::arb_busy;
          end
        end
        modarith_pkg::arb_busy: begin
          if (red_ready) begin
            state <= modarith_pkg::arb_release;
          end
        end
        // Owner drops or renews its request here
        default: begin
          state <= modarith_pkg::arb_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Result steering
  ////////////////////////////////////////

  assign add_done   = (state == modarith_pkg::arb_busy) && red_ready &&
                      (owner == modarith_pkg::own_adder);
  assign mul_done   = (state == modarith_pkg::arb_busy) && red_ready &&
                      (owner == modarith_pkg::own_multiplier);
  // Reducer holds its result until the next ready
  assign red_result = red_value;

endmodule

//--- hdl/mod_adder.sv
// Modular addition engine, (a + b) mod modulo
// Both operands go through the shared reducer first
// Modulo must stay stable while busy, a zero modulus wraps at 2^DATA_SIZE
// Start while busy is ignored

`timescale 1ns/1ns

module mod_adder (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  modarith_pkg::data_t       a,
  input  modarith_pkg::data_t       b,
  input  modarith_pkg::data_t       modulo,
  output logic                      req,
  output modarith_pkg::reduce_cmd_t cmd,
  input  logic                      done,
  input  modarith_pkg::data_t       red_result,
  output logic                      ready,
  output modarith_pkg::data_t       result
);

  modarith_pkg::engine_state_t state;

  // Latched operands and remainders
  modarith_pkg::data_t a_r;
  modarith_pkg::data_t b_r;
  modarith_pkg::data_t mod_r;
  modarith_pkg::data_t ra;
  modarith_pkg::data_t rb;

  // Sum with carry bit
  logic [modarith_pkg::DATA_SIZE:0] sum_r;

  // Reduce a first, then b
  assign cmd.value  = (state == modarith_pkg::eng_reduce_b) ? b_r : a_r;
  assign cmd.modulo = mod_r;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == modarith_pkg::eng_idle && start) begin
      a_r   <= a;
      b_r   <= b;
      mod_r <= modulo;
    end
    if (state == modarith_pkg::eng_reduce_a && done) begin
      ra <= red_result;
    end
    if (state == modarith_pkg::eng_reduce_b && done) begin
      rb <= red_result;
    end
    if (state == modarith_pkg::eng_compute) begin
      sum_r <= {1'b0, ra} + {1'b0, rb};
    end
  end

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= modarith_pkg::eng_idle;
      req    <= 1'b0;
      ready  <= 1'b0;
      result <= '0;
    end else begin
      ready <= 1'b0;
      case (state)
        modarith_pkg::eng_idle: begin
          if (start) begin
            req   <= 1'b1;
            state <= modarith_pkg::eng_reduce_a;
          end
        end
        // Request stays up, command switches to b
        modarith_pkg::eng_reduce_a: begin
          if (done) state <= modarith_pkg::eng_reduce_b;
        end
        modarith_pkg::eng_reduce_b: begin
          if (done) begin
            req   <= 1'b0;
            state <= modarith_pkg::eng_compute;
          end
        end
        modarith_pkg::eng_compute: begin
          state <= modarith_pkg::eng_finish;
        end
        default: begin
          // One correction is enough, both remainders are below modulo
          if (mod_r != '0 && sum_r >= {1'b0, mod_r}) begin
            result <= sum_r[modarith_pkg::DATA_SIZE-1:0] - mod_r;
          end else begin
            result <= sum_r[modarith_pkg::DATA_SIZE-1:0];
          end
          ready <= 1'b1;
          state <= modarith_pkg::eng_idle;
        end
      endcase
    end
  end

endmodule

//--- hdl/mod_multiplier.sv
// Modular multiplication engine, (a * b) mod modulo
// Both operands reduced through the shared reducer, then a bit-serial
// shift-and-add over DATA_SIZE cycles, MSB of b first
// Zero modulus skips corrections, result is the low DATA_SIZE bits
// Modulo must stay stable while busy, start while busy is ignored

`timescale 1ns/1ns

module mod_multiplier (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  modarith_pkg::data_t       a,
  input  modarith_pkg::data_t       b,
  input  modarith_pkg::data_t       modulo,
  output logic                      req,
  output modarith_pkg::reduce_cmd_t cmd,
  input  logic                      done,
  input  modarith_pkg::data_t       red_result,
  output logic                      ready,
  output modarith_pkg::data_t       result
);

  localparam int CNT_W = $clog2(modarith_pkg::DATA_SIZE);

  modarith_pkg::engine_state_t state;

  // Step counter, DATA_SIZE-1 down to 0
  logic [CNT_W-1:0] cnt;

  modarith_pkg::data_t a_r;
  modarith_pkg::data_t b_r;
  modarith_pkg::data_t mod_r;
  // Remainder of a, and remainder of b shifting out MSB first
  modarith_pkg::data_t ra;
  modarith_pkg::data_t rb;
  modarith_pkg::data_t acc;

  // One shift-and-add step
  logic                             mod_nz;
  logic [modarith_pkg::DATA_SIZE:0] dbl;
  logic [modarith_pkg::DATA_SIZE:0] acc_sum;
  modarith_pkg::data_t              addend;
  modarith_pkg::data_t              acc_next;

  assign cmd.value  = (state == modarith_pkg::eng_reduce_b) ? b_r : a_r;
  assign cmd.modulo = mod_r;

  assign mod_nz = (mod_r != '0);

  ////////////////////////////////////////
  // Shift-and-add step
  ////////////////////////////////////////

  always_comb begin
    // Double, fold back below modulus
    dbl = {acc, 1'b0};
    if (mod_nz && dbl >= {1'b0, mod_r}) begin
      dbl = dbl - {1'b0, mod_r};
    end
    // Add a's remainder when the current bit of b is set
    addend  = rb[modarith_pkg::DATA_SIZE-1] ? ra : '0;
    acc_sum = {1'b0, dbl[modarith_pkg::DATA_SIZE-1:0]} + {1'b0, addend};
    if (mod_nz && acc_sum >= {1'b0, mod_r}) begin
      acc_sum = acc_sum - {1'b0, mod_r};
    end
    acc_next = acc_sum[modarith_pkg::DATA_SIZE-1:0];
  end

  always_ff @(posedge CLK) begin
    if (state == modarith_pkg::eng_idle && start) begin
      a_r   <= a;
      b_r   <= b;
      mod_r <= modulo;
    end
    if (state == modarith_pkg::eng_reduce_a && done) begin
      ra <= red_result;
    end
    if (state == modarith_pkg::eng_reduce_b && done) begin
      rb  <= red_result;
      acc <= '0;
    end
    if (state == modarith_pkg::eng_compute) begin
      rb  <= rb << 1;
      acc <= acc_next;
    end
  end

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= modarith_pkg::eng_idle;
      cnt    <= '0;
      req    <= 1'b0;
      ready  <= 1'b0;
      result <= '0;
    end else begin
      ready <= 1'b0;
      case (state)
        modarith_pkg::eng_idle: begin
          if (start) begin
            req   <= 1'b1;
            state <= modarith_pkg::eng_reduce_a;
          end
        end
        modarith_pkg::eng_reduce_a: begin
          if (done) state <= modarith_pkg::eng_reduce_b;
        end
        modarith_pkg::eng_reduce_b: begin
          if (done) begin
            req   <= 1'b0;
            cnt   <= CNT_W'(modarith_pkg::DATA_SIZE - 1);
            state <= modarith_pkg::eng_compute;
          end
        end
        // Exactly DATA_SIZE steps
        modarith_pkg::eng_compute: begin
          if (cnt == '0) begin
            state <= modarith_pkg::eng_finish;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          result <= acc;
          ready  <= 1'b1;
          state  <= modarith_pkg::eng_idle;
        end
      endcase
    end
  end

endmodule

//--- hdl/modarith_unit.sv
// Scalar modular arithmetic unit, add and multiply channels
// Both channels share one reducer through a round-robin arbiter
// modulo_in is shared and must stay stable while either channel is busy

`timescale 1ns/1ns

module modarith_unit (
  input  logic                CLK,
  input  logic                RST,
  // Add channel
  input  logic                add_start,
  input  modarith_pkg::data_t add_a,
  input  modarith_pkg::data_t add_b,
  output logic                add_ready,
  output modarith_pkg::data_t add_out,
  // Multiply channel
  input  logic                mul_start,
  input  modarith_pkg::data_t mul_a,
  input  modarith_pkg::data_t mul_b,
  output logic                mul_ready,
  output modarith_pkg::data_t mul_out,
  input  modarith_pkg::data_t modulo_in
);

  ////////////////////////////////////////
  // Engine to arbiter
  ////////////////////////////////////////

  logic                      add_req;
  logic                      add_done;
  modarith_pkg::reduce_cmd_t add_cmd;
  logic                      mul_req;
  logic                      mul_done;
  modarith_pkg::reduce_cmd_t mul_cmd;
  modarith_pkg::data_t       red_result;

  // Arbiter to reducer
  logic                      red_start;
  logic                      red_ready;
  modarith_pkg::reduce_cmd_t red_cmd;
  modarith_pkg::data_t       red_value;

  mod_adder mod_adder_i (
    .CLK(CLK), .RST(RST),
    .start(add_start), .a(add_a), .b(add_b), .modulo(modulo_in),
    .req(add_req), .cmd(add_cmd), .done(add_done), .red_result(red_result),
    .ready(add_ready), .result(add_out)
  );

  mod_multiplier mod_multiplier_i (
    .CLK(CLK), .RST(RST),
    .start(mul_start), .a(mul_a), .b(mul_b), .modulo(modulo_in),
    .req(mul_req), .cmd(mul_cmd), .done(mul_done), .red_result(red_result),
    .ready(mul_ready), .result(mul_out)
  );

  reducer_arbiter reducer_arbiter_i (
    .CLK(CLK), .RST(RST),
    .add_req(add_req), .add_cmd(add_cmd), .mul_req(mul_req), .mul_cmd(mul_cmd),
    .add_done(add_done), .mul_done(mul_done), .red_result(red_result),
    .red_start(red_start), .red_cmd(red_cmd),
    .red_ready(red_ready), .red_value(red_value)
  );

  mod_reducer mod_reducer_i (
    .CLK(CLK), .RST(RST),
    .start(red_start), .cmd(red_cmd), .ready(red_ready), .result(red_value)
  );

endmodule

//--- bench/modarith_unit_properties.sv
// Protocol assertions on the shared reducer and its arbiter
// Bound into modarith_unit, sees only its internal wires
// The busy flag mirrors one reducer operation from start to ready

`timescale 1ns/1ns

module modarith_unit_properties (
  input logic CLK,
  input logic RST,
  input logic red_start,
  input logic red_ready,
  input logic add_req,
  input logic mul_req,
  input logic add_done,
  input logic mul_done,
  input logic add_start,
  input logic mul_start,
  input logic add_ready,
  input logic mul_ready
);

  // Reducer operation in flight
  logic busy;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
    end else if (red_start) begin
      busy <= 1'b1;
    end else if (red_ready) begin
      busy <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Ready is a single cycle pulse
  ready_pulse_a: assert property (@(posedge CLK) disable iff (RST)
    red_ready |=> !red_ready)
    else $error("reducer ready held longer than one cycle");

  // No second grant before the reducer answers
  start_idle_a: assert property (@(posedge CLK) disable iff (RST)
    busy |-> !red_start)
    else $error("reducer started while an operation was in flight");

  // Done reaches at most one engine, and only one still requesting
  done_excl_a: assert property (@(posedge CLK) disable iff (RST)
    !(add_done && mul_done) && (!add_done || add_req) && (!mul_done || mul_req))
    else $error("done went to both engines or to an engine without a request");

  // All strobes quiet while reset is held
  reset_quiet_a: assert property (@(posedge CLK)
    (RST && $past(RST)) |->
      !(red_start || red_ready || add_start || mul_start || add_ready || mul_ready))
    else $error("start or ready active during reset");

endmodule

bind modarith_unit modarith_unit_properties modarith_unit_properties_i (
  .CLK(CLK), .RST(RST),
  .red_start(red_start), .red_ready(red_ready),
  .add_req(add_req), .mul_req(mul_req),
  .add_done(add_done), .mul_done(mul_done),
  .add_start(add_start), .mul_start(mul_start),
  .add_ready(add_ready), .mul_ready(mul_ready)
);

//--- bench/modarith_unit_tb.sv
// Testbench for the modular arithmetic unit
// Moduli are drawn at or above 2^24 so one reduction stays under about 258 cycles
// modulo_in only changes while both channels are idle
// Expected results come from 64-bit reference arithmetic

`timescale 1ns/1ns

module modarith_unit_tb;

  localparam int     N_RAND      = 8;
  localparam int     N_EDGE      = 4;
  localparam int     N_ZERO      = 4;
  // Idle check, single and dual random runs, edge and zero-modulus runs
  localparam int     N_OPS       = 1 + 4 * N_RAND + 2 * N_EDGE + 2 * N_ZERO;
  localparam longint WATCHDOG_NS = longint'(N_OPS) * 1200 * 100;

  logic                CLK;
  logic                RST;
  logic                add_start;
  modarith_pkg::data_t add_a;
  modarith_pkg::data_t add_b;
  logic                add_ready;
  modarith_pkg::data_t add_out;
  logic                mul_start;
  modarith_pkg::data_t mul_a;
  modarith_pkg::data_t mul_b;
  logic                mul_ready;
  modarith_pkg::data_t mul_out;
  modarith_pkg::data_t modulo_in;

  integer seed;

  // Pending expectations per channel, in issue order
  modarith_pkg::data_t add_exp[$];
  string               add_names[$];
  modarith_pkg::data_t mul_exp[$];
  string               mul_names[$];

  modarith_unit modarith_unit_i (
    .CLK(CLK), .RST(RST),
    .add_start(add_start), .add_a(add_a), .add_b(add_b),
    .add_ready(add_ready), .add_out(add_out),
    .mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b),
    .mul_ready(mul_ready), .mul_out(mul_out),
    .modulo_in(modulo_in)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Zero modulus wraps at 2^32
  function automatic modarith_pkg::data_t ref_mod_add(input modarith_pkg::data_t a,
      input modarith_pkg::data_t b, input modarith_pkg::data_t m);
    logic [63:0] wide;
    if (m == '0) begin
      wide = 64'(a) + 64'(b);
    end else begin
      wide = (64'(a) % 64'(m) + 64'(b) % 64'(m)) % 64'(m);
    end
    return wide[modarith_pkg::DATA_SIZE-1:0];
  endfunction

  // Product of two remainders fits in 64 bits
  function automatic modarith_pkg::data_t ref_mod_mul(input modarith_pkg::data_t a,
      input modarith_pkg::data_t b, input modarith_pkg::data_t m);
    logic [63:0] wide;
    if (m == '0) begin
      wide = 64'(a) * 64'(b);
    end else begin
      wide = ((64'(a) % 64'(m)) * (64'(b) % 64'(m))) % 64'(m);
    end
    return wide[modarith_pkg::DATA_SIZE-1:0];
  endfunction

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic check_value(input string name, input modarith_pkg::data_t expected,
                             input modarith_pkg::data_t actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge CLK) begin
    if (!RST && add_ready) begin
      if (add_exp.size() == 0) begin
        $display("Add channel gave a ready pulse with no operation pending");
        $display("TB FAILED");
        $fatal(1, "unexpected add ready");
      end else begin
        check_value(add_names.pop_front(), add_exp.pop_front(), add_out);
      end
    end
    if (!RST && mul_ready) begin
      if (mul_exp.size() == 0) begin
        $display("Multiply channel gave a ready pulse with no operation pending");
        $display("TB FAILED");
        $fatal(1, "unexpected mul ready");
      end else begin
        check_value(mul_names.pop_front(), mul_exp.pop_front(), mul_out);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Inputs change 5 ns after the rising edge
  task automatic next_drive_point();
    @(posedge CLK);
    #5;
  endtask

  // Start one or both channels with a shared modulus, wait until both finish
  task automatic issue_ops(input string name, input bit do_add, input bit do_mul,
                           input modarith_pkg::data_t ax, input modarith_pkg::data_t ay,
                           input modarith_pkg::data_t mx, input modarith_pkg::data_t my,
                           input modarith_pkg::data_t m);
    modulo_in = m;
    add_a     = ax;
    add_b     = ay;
    mul_a     = mx;
    mul_b     = my;
    add_start = do_add;
    mul_start = do_mul;
    if (do_add) begin
      add_names.push_back({name, "_add"});
      add_exp.push_back(ref_mod_add(ax, ay, m));
    end
    if (do_mul) begin
      mul_names.push_back({name, "_mul"});
      mul_exp.push_back(ref_mod_mul(mx, my, m));
    end
    next_drive_point();
    add_start = 1'b0;
    mul_start = 1'b0;
    while (add_exp.size() != 0 || mul_exp.size() != 0) begin
      next_drive_point();
    end
  endtask

  initial begin : stimulus
    modarith_pkg::data_t m;
    modarith_pkg::data_t x;
    modarith_pkg::data_t y;
    modarith_pkg::data_t u;
    modarith_pkg::data_t v;
    seed      = 32'hfc58_7b42;
    CLK       = 1'b0;
    RST       = 1'b1;
    add_start = 1'b0;
    add_a     = '0;
    add_b     = '0;
    mul_start = 1'b0;
    mul_a     = '0;
    mul_b     = '0;
    modulo_in = '0;
    repeat (10) @(posedge CLK);
    #5;
    RST = 1'b0;

    // Quiet after reset, outputs stay zero
    repeat (20) next_drive_point();
    check_value("idle_add_out", '0, add_out);
    check_value("idle_mul_out", '0, mul_out);

    for (int i = 0; i < N_RAND; i++) begin
      m = $random(seed) | 32'h0100_0000;
      x = $random(seed);
      y = $random(seed);
      issue_ops($sformatf("add_only_%0d", i), 1'b1, 1'b0, x, y, '0, '0, m);
    end
    for (int i = 0; i < N_RAND; i++) begin
      m = $random(seed) | 32'h0100_0000;
      x = $random(seed);
      y = $random(seed);
      issue_ops($sformatf("mul_only_%0d", i), 1'b0, 1'b1, '0, '0, x, y, m);
    end
    // Same-cycle starts, both engines contend for the reducer
    for (int i = 0; i < N_RAND; i++) begin
      m = $random(seed) | 32'h0100_0000;
      x = $random(seed);
      y = $random(seed);
      u = $random(seed);
      v = $random(seed);
      issue_ops($sformatf("dual_%0d", i), 1'b1, 1'b1, x, y, u, v, m);
    end

    // Edge operands around the modulus
    m = $random(seed) | 32'h0100_0000;
    issue_ops("edge_mod_below", 1'b1, 1'b1, m, m - 1, m, m - 1, m);
    issue_ops("edge_zeros", 1'b1, 1'b1, '0, '0, '0, '0, m);
    issue_ops("edge_both_below", 1'b1, 1'b1, m - 1, m - 1, m - 1, m - 1, m);
    issue_ops("edge_mod_zero", 1'b1, 1'b1, m, '0, '0, m, m);

    // Zero modulus gives plain 32-bit wrap
    issue_ops("zero_mod_ones", 1'b1, 1'b1, '1, '1, '1, '1, '0);
    for (int i = 1; i < N_ZERO; i++) begin
      x = $random(seed);
      y = $random(seed);
      u = $random(seed);
      v = $random(seed);
      issue_ops($sformatf("zero_mod_%0d", i), 1'b1, 1'b1, x, y, u, v, '0);
    end

    $display("TB PASSED");
    $finish;
  end

  // Bound from the operation count, 1200 cycles per operation
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog timeout, operations did not finish in time");
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- build.f
hdl/modarith_pkg.sv
hdl/mod_reducer.sv
hdl/reducer_arbiter.sv
hdl/mod_adder.sv
hdl/mod_multiplier.sv
hdl/modarith_unit.sv
bench/modarith_unit_properties.sv
bench/modarith_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the modular arithmetic testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f \
  --top-module modarith_unit_tb -Mdir obj_dir || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vmodarith_unit_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}
